// File: vlog.f
verilog/simple_processor_pkg.sv
verilog/exec_if.sv
verilog/fetch_seq.sv
verilog/ins_dec.sv
verilog/reg_file.sv
verilog/alu_unit.sv
verilog/lsu_unit.sv
verilog/writeback_sel.sv
verilog/simple_processor.sv
verif/tb_mem.sv
verif/tb_simple_processor.sv

// File: run.sh
#!/bin/sh
# build and run the testbench with Verilator, result from the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing -f vlog.f --top-module tb_simple_processor -o tb_simple_processor
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_simple_processor > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Test FAILED" sim.log; then
  exit 1
fi
exit 0

// File: verif/tb_simple_processor.sv
`timescale 1ns/1ps

module tb_simple_processor import simple_processor_pkg::*; ();

  localparam int BODY_LEN  = 40;  // random instructions between setup and dump
  localparam int NUM_TESTS = 4;

  logic   clk = 1'b0;
  logic   arst_n;
  addr_t  boot_addr;
  logic   imem_req, imem_ack, dmem_req, dmem_we, dmem_ack;
  addr_t  imem_addr, dmem_addr;
  instr_t imem_rdata;
  data_t  dmem_wdata, dmem_rdata;

  integer seed;
  data_t  regs [8];      // model register file
  data_t  mem_w [int];   // model stores, word indexed
  addr_t  exp_wa [$];
  data_t  exp_wd [$];
  addr_t  act_wa [$];
  data_t  act_wd [$];
  int     exp_acc = 0;
  int     act_acc = 0;
  int     n_fetch = 0;
  int     prog_len = 0;
  addr_t  gen_pc, last_fetch, held_addr;
  data_t  held_wd;
  logic   held_we;
  logic   d_held = 1'b0;  // dmem request seen without ack
  string  test_name [NUM_TESTS] = '{"boot_fetch", "fetch_seq", "dmem_hold", "store_stream"};
  int     errs [NUM_TESTS] = '{default: 0};
  int     checks [NUM_TESTS] = '{default: 0};

  always #2 clk = ~clk;  // 4 ns period

  simple_processor #(.MEM_ADDR_WIDTH(ADDR_WIDTH), .MEM_DATA_WIDTH(DATA_WIDTH))
      simple_processor_i (
    .clk_i(clk), .arst_ni(arst_n), .boot_addr_i(boot_addr),
    .imem_req_o(imem_req), .imem_addr_o(imem_addr),
    .imem_rdata_i(imem_rdata), .imem_ack_i(imem_ack),
    .dmem_req_o(dmem_req), .dmem_we_o(dmem_we), .dmem_addr_o(dmem_addr),
    .dmem_wdata_o(dmem_wdata), .dmem_rdata_i(dmem_rdata), .dmem_ack_i(dmem_ack)
  );

  tb_mem #(.SEED(98)) mem_i (
    .clk_i(clk), .imem_req_i(imem_req), .imem_addr_i(imem_addr),
    .imem_rdata_o(imem_rdata), .imem_ack_o(imem_ack),
    .dmem_req_i(dmem_req), .dmem_we_i(dmem_we), .dmem_addr_i(dmem_addr),
    .dmem_wdata_i(dmem_wdata), .dmem_rdata_o(dmem_rdata), .dmem_ack_o(dmem_ack)
  );

  ////////////////////////////////
  // checks
  ////////////////////////////////

  task automatic check_addr(input int t, input string what, input addr_t exp, input addr_t act);
    checks[t]++;
    if (exp !== act) begin
      $display("mismatch %s %s: expected %h, actual %h", test_name[t], what, exp, act);
      errs[t]++;
    end
  endtask

  task automatic check_data(input int t, input string what, input data_t exp, input data_t act);
    checks[t]++;
    if (exp !== act) begin
      $display("mismatch %s %s: expected %h, actual %h", test_name[t], what, exp, act);
      errs[t]++;
    end
  endtask

  task automatic note_failure(input int t, input string what);
    checks[t]++;
    errs[t]++;
    $display("%s: %s", test_name[t], what);
  endtask

  ////////////////////////////////
  // reference model
  ////////////////////////////////

  function automatic int rnd(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  // preset data word, mixes all index bits
  function automatic data_t fill_word(input int idx);
    return data_t'(idx * 40503) ^ data_t'(idx >> 7) ^ 16'h5a5a;
  endfunction

  function automatic data_t model_load(input addr_t a);
    if (mem_w.exists(int'(a[15:1]))) return mem_w[int'(a[15:1])];
    return fill_word(int'(a[15:1]));
  endfunction

  task automatic model_step(input instr_t w);
    data_t a, b, imm;
    addr_t ea;
    a   = regs[w[8:6]];
    b   = regs[w[5:3]];
    imm = {{10{w[5]}}, w[5:0]};  // sign extended 6-bit immediate
    ea  = a + imm;
    case (w[15:12])
      ADD:  regs[w[11:9]] = a + b;
      SUB:  regs[w[11:9]] = a - b;
      AND:  regs[w[11:9]] = a & b;
      OR:   regs[w[11:9]] = a | b;
      XOR:  regs[w[11:9]] = a ^ b;
      ADDI: regs[w[11:9]] = a + imm;
      LOAD: begin
        regs[w[11:9]] = model_load(ea);
        exp_acc++;
      end
      STORE: begin
        exp_wa.push_back(ea);
        exp_wd.push_back(regs[w[11:9]]);  // rd field names the data
        mem_w[int'(ea[15:1])] = regs[w[11:9]];
        exp_acc++;
      end
      default: ;  // NOP and unknown opcodes
    endcase
  endtask

  // place one word in program memory and run it on the model
  task automatic emit(input logic [3:0] op, input int rd, input int rs1, input int low);
    instr_t w;
    w = {op, 3'(rd), 3'(rs1), 6'(low)};
    mem_i.imem[gen_pc[15:1]] = w;
    model_step(w);
    gen_pc = gen_pc + 16'd2;
    prog_len++;
  endtask

  task automatic build_program();
    int rd;
    for (int r = 0; r < 8; r++) emit(LOAD, r, rnd(8), rnd(64));  // registers from presets
    for (int k = 0; k < BODY_LEN; k++) begin
      rd = rnd(8);
      case (rnd(8))
        0, 1, 2: emit(4'(1 + rnd(5)), rd, rnd(8), rnd(64));  // ADD to XOR
        3: emit(ADDI, rd, rnd(8), rnd(64));                  // negative imm too
        4: begin
          emit(LOAD, rd, rnd(8), rnd(64));
          emit(STORE, rd, rnd(8), rnd(64));                  // stores the loaded word
        end
        5: emit(STORE, rd, rnd(8), rnd(64));
        6: emit(NOP, rd, rnd(8), rnd(64));
        default: emit(4'(9 + rnd(7)), rd, rnd(8), rnd(64)); // unknown opcode
      endcase
    end
    for (int r = 0; r < 8; r++) emit(STORE, r, 0, 2 * r);    // dump every register
  endtask

  function automatic logic prog_done();
    return act_wa.size() >= exp_wa.size() && n_fetch > prog_len;
  endfunction

  ////////////////////////////////
  // monitors
  ////////////////////////////////

  always @(posedge clk) begin
    if (arst_n) begin
      if (imem_req && imem_ack) begin
        if (n_fetch == 0) check_addr(0, "first fetch", boot_addr, imem_addr);
        else check_addr(1, $sformatf("fetch %0d", n_fetch), last_fetch + 16'd2, imem_addr);
        last_fetch = imem_addr;
        n_fetch++;
      end
      if (d_held && !dmem_req) note_failure(2, "dmem request dropped before ack");
      if (dmem_req) begin
        if (d_held) begin
          check_addr(2, "held address", held_addr, dmem_addr);
          check_data(2, "held write data", held_wd, dmem_wdata);
          if (held_we !== dmem_we) note_failure(2, "dmem write enable changed before ack");
        end
        held_addr = dmem_addr;
        held_wd   = dmem_wdata;
        held_we   = dmem_we;
        d_held    = !dmem_ack;
        if (dmem_ack) begin
          act_acc++;
          if (dmem_we) begin
            act_wa.push_back(dmem_addr);
            act_wd.push_back(dmem_wdata);
          end
        end
      end else begin
        d_held = 1'b0;
      end
    end
  end

  ////////////////////////////////
  // main sequence
  ////////////////////////////////

  initial begin
    int    wait_cyc;
    int    total_errs;
    int    failed;
    logic  timed_out;
    string why;
    seed      = 98;
    arst_n    = 1'b0;
    timed_out = 1'b0;
    for (int r = 0; r < 8; r++) regs[r] = '0;
    for (int k = 0; k < 2**15; k++) begin
      mem_i.dmem[k] = fill_word(k);
      mem_i.imem[k] = {4'h0, 12'(k ^ (k >> 3))};  // NOP words past the program
    end
    boot_addr = addr_t'(rnd(65536)) & 16'hfffe;  // any even address
    gen_pc    = boot_addr;
    build_program();

    repeat (2) @(negedge clk);
    arst_n = 1'b1;

    wait_cyc = 0;
    while (n_fetch == 0 && wait_cyc < 20) begin
      @(negedge clk);
      wait_cyc++;
    end
    if (n_fetch == 0) begin
      timed_out = 1'b1;
      why = "no instruction request before timeout";
    end
    if (!timed_out) begin
      wait_cyc = 0;
      while (!prog_done() && wait_cyc < 40 * prog_len) begin
        @(negedge clk);
        wait_cyc++;
      end
      if (!prog_done()) begin
        timed_out = 1'b1;
        why = "program did not finish before timeout";
      end
    end

    check_data(3, "write count", data_t'(exp_wa.size()), data_t'(act_wa.size()));
    check_data(3, "access count", data_t'(exp_acc), data_t'(act_acc));  // NOPs add none
    for (int k = 0; k < exp_wa.size() && k < act_wa.size(); k++) begin
      check_addr(3, $sformatf("store %0d address", k), exp_wa[k], act_wa[k]);
      check_data(3, $sformatf("store %0d data", k), exp_wd[k], act_wd[k]);
    end

    if (timed_out) $display("%s", why);
    total_errs = 0;
    failed     = 0;
    for (int t = 0; t < NUM_TESTS; t++) begin
      $display("test %s: %0d checks, %0d errors", test_name[t], checks[t], errs[t]);
      total_errs += errs[t];
      if (errs[t] != 0) failed++;
    end
    $display("%0d tests, %0d failed, %0d errors", NUM_TESTS, failed, total_errs);
    if (timed_out || total_errs != 0) begin
      $display("Test FAILED");
    end else begin
      $display("Test OK");
    end
    $finish;
  end

endmodule

// File: verif/tb_mem.sv
`timescale 1ns/1ps

// instruction and data memory, each request acked after 0 to 3 cycles
module tb_mem import simple_processor_pkg::*; #(
  parameter int SEED = 98
) (
  input  logic   clk_i,
  input  logic   imem_req_i,
  input  addr_t  imem_addr_i,
  output instr_t imem_rdata_o,
  output logic   imem_ack_o,
  input  logic   dmem_req_i,
  input  logic   dmem_we_i,
  input  addr_t  dmem_addr_i,
  input  data_t  dmem_wdata_i,
  output data_t  dmem_rdata_o,
  output logic   dmem_ack_o
);

  instr_t imem [2**15];   // word indexed by addr[15:1], program from the testbench
  data_t  dmem [2**15];   // preset data words
  data_t  wr_mem [int];   // words written by the DUT
  integer seed = SEED;
  int     i_wait = 0;     // cycles left before the next imem ack
  int     d_wait = 0;
  logic   i_ack = 1'b0;
  logic   d_ack = 1'b0;
  instr_t i_rdata = '0;
  data_t  d_rdata = '0;

  // responses change on the falling edge only
  always @(negedge clk_i) begin
    i_ack <= 1'b0;
    d_ack <= 1'b0;
    if (imem_req_i && !i_ack) begin
      if (i_wait == 0) begin
        i_ack   <= 1'b1;
        i_rdata <= imem[imem_addr_i[15:1]];
        i_wait  <= $random(seed) & 3;  // delay for the next request
      end else begin
        i_wait <= i_wait - 1;
      end
    end
    if (dmem_req_i && !d_ack) begin
      if (d_wait == 0) begin
        d_ack  <= 1'b1;
        d_wait <= $random(seed) & 3;
        if (dmem_we_i) begin
          wr_mem[int'(dmem_addr_i[15:1])] = dmem_wdata_i;
        end else if (wr_mem.exists(int'(dmem_addr_i[15:1]))) begin
          d_rdata <= wr_mem[int'(dmem_addr_i[15:1])];  // written earlier
        end else begin
          d_rdata <= dmem[dmem_addr_i[15:1]];
        end
      end else begin
        d_wait <= d_wait - 1;
      end
    end
  end

  assign imem_ack_o   = i_ack;
  assign imem_rdata_o = i_rdata;
  assign dmem_ack_o   = d_ack;
  assign dmem_rdata_o = d_rdata;

endmodule

// File: verilog/simple_processor.sv
`timescale 1ns/1ps

module simple_processor import simple_processor_pkg::*; #(
  parameter int MEM_ADDR_WIDTH = ADDR_WIDTH,
  parameter int MEM_DATA_WIDTH = DATA_WIDTH
) (
  input  logic   clk_i,
  input  logic   arst_ni,
  input  addr_t  boot_addr_i,
  // instruction port
  output logic   imem_req_o,
  output addr_t  imem_addr_o,
  input  instr_t imem_rdata_i,
  input  logic   imem_ack_i,
  // data port
  output logic   dmem_req_o,
  output logic   dmem_we_o,
  output addr_t  dmem_addr_o,
  output data_t  dmem_wdata_o,
  input  data_t  dmem_rdata_i,
  input  logic   dmem_ack_i
);

  ////////////////////////////////
  // wires
  ////////////////////////////////

  instr_t    instr;
  logic      issue;
  logic      retire;
  reg_addr_t rs1_addr, rs2_addr;
  data_t     rs1_data, rs2_data;
  logic      alu_done, alu_we;
  reg_addr_t alu_rd;
  data_t     alu_result;
  logic      lsu_done, lsu_we;
  reg_addr_t lsu_rd;
  data_t     lsu_data;
  logic      rf_we;
  reg_addr_t rf_addr;
  data_t     rf_data;

  exec_if exec_bus ();  // decoder to both units

  ////////////////////////////////
  // blocks
  ////////////////////////////////

  fetch_seq #(.MEM_ADDR_WIDTH(MEM_ADDR_WIDTH)) fetch_seq_i (
    .clk_i, .arst_ni, .boot_addr_i,
    .retire_i(retire),
    .imem_req_o, .imem_addr_o, .imem_rdata_i, .imem_ack_i,
    .instr_o(instr), .issue_o(issue)
  );

  ins_dec ins_dec_i (
    .instr_i(instr), .issue_i(issue),
    .rs1_addr_o(rs1_addr), .rs2_addr_o(rs2_addr),
    .rs1_data_i(rs1_data), .rs2_data_i(rs2_data),
    .exec(exec_bus.issuer)
  );

  reg_file reg_file_i (
    .clk_i, .arst_ni,
    .rs1_addr_i(rs1_addr), .rs2_addr_i(rs2_addr),
    .rd_addr_i(rf_addr), .rd_data_i(rf_data), .we_i(rf_we),
    .rs1_data_o(rs1_data), .rs2_data_o(rs2_data)
  );

  alu_unit alu_unit_i (
    .clk_i, .arst_ni, .exec(exec_bus.unit),
    .done_o(alu_done), .we_o(alu_we), .rd_addr_o(alu_rd), .result_o(alu_result)
  );

  lsu_unit #(.MEM_ADDR_WIDTH(MEM_ADDR_WIDTH), .MEM_DATA_WIDTH(MEM_DATA_WIDTH)) lsu_unit_i (
    .clk_i, .arst_ni, .exec(exec_bus.unit),
    .dmem_req_o, .dmem_we_o, .dmem_addr_o, .dmem_wdata_o, .dmem_rdata_i, .dmem_ack_i,
    .done_o(lsu_done), .we_o(lsu_we), .rd_addr_o(lsu_rd), .load_data_o(lsu_data)
  );

  writeback_sel writeback_sel_i (
    .alu_done_i(alu_done), .alu_we_i(alu_we), .alu_rd_i(alu_rd), .alu_result_i(alu_result),
    .lsu_done_i(lsu_done), .lsu_we_i(lsu_we), .lsu_rd_i(lsu_rd), .lsu_data_i(lsu_data),
    .rf_we_o(rf_we), .rf_addr_o(rf_addr), .rf_data_o(rf_data),
    .retire_o(retire)
  );

endmodule

// File: verilog/writeback_sel.sv
`timescale 1ns/1ps

module writeback_sel import simple_processor_pkg::*; (
  input  logic      alu_done_i,
  input  logic      alu_we_i,
  input  reg_addr_t alu_rd_i,
  input  data_t     alu_result_i,
  input  logic      lsu_done_i,
  input  logic      lsu_we_i,
  input  reg_addr_t lsu_rd_i,
  input  data_t     lsu_data_i,
  output logic      rf_we_o,
  output reg_addr_t rf_addr_o,
  output data_t     rf_data_o,
  output logic      retire_o
);

  // one instruction in flight, so at most one done at a time
  always_comb begin
    if (lsu_done_i) begin
      rf_addr_o = lsu_rd_i;
      rf_data_o = lsu_data_i;
    end else begin
      rf_addr_o = alu_rd_i;
      rf_data_o = alu_result_i;
    end
  end

  assign rf_we_o  = (alu_done_i && alu_we_i) || (lsu_done_i && lsu_we_i);
  assign retire_o = alu_done_i || lsu_done_i;  // same cycle as the write

endmodule

// File: verilog/lsu_unit.sv
`timescale 1ns/1ps

module lsu_unit import simple_processor_pkg::*; #(
  parameter int MEM_ADDR_WIDTH = ADDR_WIDTH,
  parameter int MEM_DATA_WIDTH = DATA_WIDTH
) (
  input  logic                      clk_i,
  input  logic                      arst_ni,
  exec_if.unit                      exec,
  output logic                      dmem_req_o,
  output logic                      dmem_we_o,
  output logic [MEM_ADDR_WIDTH-1:0] dmem_addr_o,
  output logic [MEM_DATA_WIDTH-1:0] dmem_wdata_o,
  input  logic [MEM_DATA_WIDTH-1:0] dmem_rdata_i,
  input  logic                      dmem_ack_i,
  output logic                      done_o,
  output logic                      we_o,
  output reg_addr_t                 rd_addr_o,
  output data_t                     load_data_o
);

  typedef enum logic [1:0] {IDLE, REQ, DONE} lsu_state_t;

  lsu_state_t                state_q;
  logic                      claim;
  logic                      store_q;  // 1 store, 0 load
  logic [MEM_ADDR_WIDTH-1:0] addr_q;
  logic [MEM_DATA_WIDTH-1:0] wdata_q;
  reg_addr_t                 rd_q;
  data_t                     load_q;

  assign claim = exec.issue && (exec.func inside {LOAD, STORE});

  ////////////////////////////////
  // request FSM
  ////////////////////////////////

  always_ff @(posedge clk_i or negedge arst_ni) begin
    if (!arst_ni) begin
      state_q <= IDLE;
      store_q <= 1'b0;
    end else begin
      case (state_q)
        IDLE: if (claim) begin
          state_q <= REQ;
          store_q <= (exec.func == STORE);
        end
        REQ:     if (dmem_ack_i) state_q <= DONE;  // held until ack
        DONE:    state_q <= IDLE;
        default: state_q <= IDLE;
      endcase
    end
  end

  // payload, stable for the whole request
  always_ff @(posedge clk_i) begin
    if (state_q == IDLE && claim) begin
      addr_q  <= MEM_ADDR_WIDTH'(exec.op_a + exec.imm);  // rs1 + sext(imm)
      wdata_q <= MEM_DATA_WIDTH'(exec.op_b);             // rd data on store
      rd_q    <= exec.rd;
    end
    if (state_q == REQ && dmem_ack_i) begin
      load_q <= data_t'(dmem_rdata_i);  // rdata valid in ack cycle
    end
  end

  assign dmem_req_o   = (state_q == REQ);
  assign dmem_we_o    = (state_q == REQ) && store_q;
  assign dmem_addr_o  = addr_q;
  assign dmem_wdata_o = wdata_q;
  assign done_o       = (state_q == DONE);             // cycle after ack
  assign we_o         = (state_q == DONE) && !store_q; // only loads write back
  assign rd_addr_o    = rd_q;
  assign load_data_o  = load_q;

endmodule

// File: verilog/alu_unit.sv
`timescale 1ns/1ps

module alu_unit import simple_processor_pkg::*; (
  input  logic      clk_i,
  input  logic      arst_ni,
  exec_if.unit      exec,
  output logic      done_o,
  output logic      we_o,
  output reg_addr_t rd_addr_o,
  output data_t     result_o
);

  logic  claim;   // this op belongs to the alu
  data_t result;  // combinational result
  logic  done_q;
  logic  we_q;
  reg_addr_t rd_q;
  data_t result_q;

  assign claim = exec.issue && (exec.func inside {NOP, ADD, SUB, AND, OR, XOR, ADDI});

  always_comb begin
    case (exec.func)
      ADD:     result = exec.op_a + exec.op_b;  // wraps mod 2^16
      SUB:     result = exec.op_a - exec.op_b;
      AND:     result = exec.op_a & exec.op_b;
      OR:      result = exec.op_a | exec.op_b;
      XOR:     result = exec.op_a ^ exec.op_b;
      ADDI:    result = exec.op_a + exec.imm;
      default: result = '0;                     // NOP
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_ni) begin
    if (!arst_ni) begin
      done_q <= 1'b0;
      we_q   <= 1'b0;
    end else begin
      done_q <= claim;                          // one cycle after issue
      we_q   <= claim && (exec.func != NOP);    // NOP retires silently
    end
  end

  always_ff @(posedge clk_i) begin
    if (claim) begin
      rd_q     <= exec.rd;
      result_q <= result;
    end
  end

  assign done_o    = done_q;
  assign we_o      = we_q;
  assign rd_addr_o = rd_q;
  assign result_o  = result_q;

endmodule

// File: verilog/reg_file.sv
`timescale 1ns/1ps

module reg_file import simple_processor_pkg::*; (
  input  logic      clk_i,
  input  logic      arst_ni,
  input  reg_addr_t rs1_addr_i,
  input  reg_addr_t rs2_addr_i,
  input  reg_addr_t rd_addr_i,
  input  data_t     rd_data_i,
  input  logic      we_i,
  output data_t     rs1_data_o,
  output data_t     rs2_data_o
);

  localparam int NUM_REGS = 2 ** REG_ADDR_WIDTH;

  data_t regs_q [NUM_REGS];  // r0 is an ordinary register

  // single write port
  always_ff @(posedge clk_i or negedge arst_ni) begin
    if (!arst_ni) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i) begin
      regs_q[rd_addr_i] <= rd_data_i;
    end
  end

  // two async read ports
  assign rs1_data_o = regs_q[rs1_addr_i];
  assign rs2_data_o = regs_q[rs2_addr_i];

endmodule

// File: verilog/ins_dec.sv
`timescale 1ns/1ps

module ins_dec import simple_processor_pkg::*; (
  input  instr_t    instr_i,
  input  logic      issue_i,
  output reg_addr_t rs1_addr_o,
  output reg_addr_t rs2_addr_o,
  input  data_t     rs1_data_i,
  input  data_t     rs2_data_i,
  exec_if.issuer    exec
);

  logic [OPC_WIDTH-1:0] opc;
  func_t                func;
  reg_addr_t            rd_addr;
  imm_t                 imm_raw;

  assign opc     = instr_i[OPC_LSB +: OPC_WIDTH];
  assign rd_addr = instr_i[RD_LSB +: REG_ADDR_WIDTH];
  assign imm_raw = instr_i[IMM_LSB +: IMM_WIDTH];

  // opcode to func, anything unknown runs as NOP
  always_comb begin
    case (opc)
      ADD, SUB, AND, OR, XOR,
      ADDI, LOAD, STORE: func = func_t'(opc);
      default:           func = NOP;
    endcase
  end

  // register file read addresses
  assign rs1_addr_o = instr_i[RS1_LSB +: REG_ADDR_WIDTH];
  assign rs2_addr_o = (func == STORE) ? rd_addr  // store data lives in rd
                                      : instr_i[RS2_LSB +: REG_ADDR_WIDTH];

  ////////////////////////////////
  // drive the exec bus
  ////////////////////////////////

  assign exec.issue = issue_i;
  assign exec.func  = func;
  assign exec.rd    = rd_addr;
  assign exec.op_a  = rs1_data_i;
  assign exec.op_b  = rs2_data_i;
  assign exec.imm   = {{(DATA_WIDTH-IMM_WIDTH){imm_raw[IMM_WIDTH-1]}}, imm_raw};  // sign ext

endmodule

// File: verilog/fetch_seq.sv
`timescale 1ns/1ps

module fetch_seq import simple_processor_pkg::*; #(
  parameter int MEM_ADDR_WIDTH = ADDR_WIDTH
) (
  input  logic                      clk_i,
  input  logic                      arst_ni,
  input  logic [MEM_ADDR_WIDTH-1:0] boot_addr_i,
  input  logic                      retire_i,     // from writeback
  output logic                      imem_req_o,
  output logic [MEM_ADDR_WIDTH-1:0] imem_addr_o,
  input  instr_t                    imem_rdata_i,
  input  logic                      imem_ack_i,
  output instr_t                    instr_o,      // latched word to decoder
  output logic                      issue_o
);

  typedef enum logic [1:0] {
    BOOT,   // load boot address
    FETCH,  // req held until ack
    ISSUE,  // one cycle, starts the units
    EXEC    // wait for retire
  } fetch_state_t;

  fetch_state_t              state_q;
  fetch_state_t              state_d;
  logic [MEM_ADDR_WIDTH-1:0] pc_q;
  instr_t                    instr_q;

  ////////////////////////////////
  // next state
  ////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      BOOT:  state_d = FETCH;
      FETCH: if (imem_ack_i) state_d = ISSUE;
      ISSUE: state_d = EXEC;
      EXEC:  if (retire_i) state_d = FETCH;  // back-pressure just stretches here
      default: state_d = BOOT;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_ni) begin
    if (!arst_ni) begin
      state_q <= BOOT;
      pc_q    <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == BOOT) begin
        pc_q <= boot_addr_i;
      end else if (state_q == EXEC && retire_i) begin
        pc_q <= pc_q + MEM_ADDR_WIDTH'(2);  // 16-bit instructions
      end
    end
  end

  // instruction word, captured in the ack cycle
  always_ff @(posedge clk_i) begin
    if (state_q == FETCH && imem_ack_i) begin
      instr_q <= imem_rdata_i;
    end
  end

  ////////////////////////////////
  // outputs
  ////////////////////////////////

  assign imem_req_o  = (state_q == FETCH);
  assign imem_addr_o = pc_q;
  assign instr_o     = instr_q;
  assign issue_o     = (state_q == ISSUE);  // exactly once per instruction

endmodule

// File: verilog/exec_if.sv
`timescale 1ns/1ps

// one decoded operation, broadcast to both units
interface exec_if import simple_processor_pkg::*; ();

  logic      issue;  // single cycle strobe
  func_t     func;
  reg_addr_t rd;     // destination index
  data_t     op_a;   // rs1 data
  data_t     op_b;   // rs2 data, rd data for STORE
  data_t     imm;    // already sign extended

  modport issuer (
    output issue, func, rd, op_a, op_b, imm
  );

  modport unit (
    input issue, func, rd, op_a, op_b, imm
  );

endinterface

// File: verilog/simple_processor_pkg.sv
package simple_processor_pkg;

  ////////////////////////////////
  // widths
  ////////////////////////////////

  localparam int ADDR_WIDTH     = 16;  // default memory address width
  localparam int DATA_WIDTH     = 16;  // default memory data width
  localparam int INSTR_WIDTH    = 16;
  localparam int REG_ADDR_WIDTH = 3;   // 8 registers
  localparam int IMM_WIDTH      = 6;
  localparam int OPC_WIDTH      = 4;

  // instruction field positions, lsb of each field
  localparam int OPC_LSB = 12;  // 15:12
  localparam int RD_LSB  = 9;   // 11:9
  localparam int RS1_LSB = 6;   // 8:6
  localparam int RS2_LSB = 3;   // 5:3
  localparam int IMM_LSB = 0;   // 5:0, overlaps rs2

  ////////////////////////////////
  // types
  ////////////////////////////////

  typedef logic [ADDR_WIDTH-1:0]     addr_t;      // byte address
  typedef logic [DATA_WIDTH-1:0]     data_t;      // register / memory word
  typedef logic [INSTR_WIDTH-1:0]    instr_t;
  typedef logic [REG_ADDR_WIDTH-1:0] reg_addr_t;
  typedef logic signed [IMM_WIDTH-1:0] imm_t;     // raw immediate field

  // values equal the opcode field
  typedef enum logic [OPC_WIDTH-1:0] {
    NOP   = 4'd0,
    ADD   = 4'd1,
    SUB   = 4'd2,
    AND   = 4'd3,
    OR    = 4'd4,
    XOR   = 4'd5,
    ADDI  = 4'd6,  // rs1 + sext(imm)
    LOAD  = 4'd7,  // rd <- mem[rs1 + sext(imm)]
    STORE = 4'd8   // mem[rs1 + sext(imm)] <- rd
  } func_t;

endpackage
